//--- ex_pkg.sv
// shared widths, opcode and unit enums, issue, branch and write-back structs
package ex_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    // scoreboard transaction id
    localparam int unsigned TRANS_ID_W     = 3;
    localparam int unsigned CSR_ADDR_W     = 12;
    // struct payloads stay at this width, the datapath follows DATA_W
    localparam int unsigned DATA_W_DEFAULT = 32;

    // ------------------------------------------------------------------
    // opcodes and target units
    // ------------------------------------------------------------------
    typedef enum logic [5:0] {
        // alu
        ADD, SUB, AND, OR, XOR, SLL, SRL, SLT, SLTU,
        // branch and jump
        BEQ, BNE, BLT, BGEU, JAL,
        // csr and multiply
        CSRRW, MUL
    } fu_op_e;

    typedef enum logic [2:0] {
        NONE, ALU, BRANCH, CSR, MULT
    } fu_unit_e;

    // one issue slot, held by the issuer until accepted
    typedef struct packed {
        logic                            valid;
        fu_unit_e                        unit;
        fu_op_e                          op;
        logic [DATA_W_DEFAULT-1:0]       operand_a;
        logic [DATA_W_DEFAULT-1:0]       operand_b;
        logic [DATA_W_DEFAULT-1:0]       imm;
        logic [TRANS_ID_W-1:0]           trans_id;
    } issue_slot_t;

    // prediction made by the frontend for the branch in slot 0
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } branch_predict_t;

    // branch resolution back to the frontend
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] target;
        logic        is_taken;
        logic        is_mispredict;
    } bp_resolve_t;

    // fixed-latency write-back into the scoreboard
    typedef struct packed {
        logic                            valid;
        logic                            flush;
        logic [TRANS_ID_W-1:0]           trans_id;
        logic [DATA_W_DEFAULT-1:0]       result;
    } wb_port_t;

endpackage

//--- ex_alu.sv
// combinational integer alu with branch comparison output
`timescale 1ns/10ps

module ex_alu #(
    parameter int unsigned DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input  ex_pkg::issue_slot_t data_i,
    output logic [DATA_W-1:0]   result_o,
    output logic                cmp_o
);
    import ex_pkg::*;

    localparam int unsigned SHAMT_W = $clog2(DATA_W);

    logic [DATA_W-1:0] a, b;
    logic              lt_s, lt_u;

    assign a    = data_i.operand_a[DATA_W-1:0];
    assign b    = data_i.operand_b[DATA_W-1:0];
    // shared comparators for slt and branches
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    // result path
    always_comb begin
        case (data_i.op)
            ADD:     result_o = a + b;
            SUB:     result_o = a - b;
            AND:     result_o = a & b;
            OR:      result_o = a | b;
            XOR:     result_o = a ^ b;
            SLL:     result_o = a << b[SHAMT_W-1:0];
            SRL:     result_o = a >> b[SHAMT_W-1:0];
            SLT:     result_o = {{(DATA_W-1){1'b0}}, lt_s};
            SLTU:    result_o = {{(DATA_W-1){1'b0}}, lt_u};
            // branch ops produce no alu result
            default: result_o = '0;
        endcase
    end

    // branch condition
    always_comb begin
        case (data_i.op)
            BEQ:     cmp_o = (a == b);
            BNE:     cmp_o = (a != b);
            BLT:     cmp_o = lt_s;
            BGEU:    cmp_o = ~lt_u;
            default: cmp_o = 1'b0;
        endcase
    end

endmodule

//--- ex_branch_unit.sv
// branch target, link value and mispredict resolution
`timescale 1ns/10ps

module ex_branch_unit #(
    parameter int unsigned DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input  ex_pkg::issue_slot_t     data_i,
    input  logic [31:0]             pc_i,
    input  ex_pkg::branch_predict_t predict_i,
    input  logic                    cmp_i,
    output logic [DATA_W-1:0]       result_o,
    output ex_pkg::bp_resolve_t     resolved_o
);
    import ex_pkg::*;

    logic        is_jal;
    logic        taken;
    logic [31:0] link;
    logic [31:0] target;

    assign is_jal = (data_i.op == JAL);
    // jal always taken, others follow the alu compare
    assign taken  = data_i.valid & (is_jal | cmp_i);
    assign link   = pc_i + 32'd4;
    assign target = taken ? (pc_i + data_i.imm) : link;

    // link register value only for jal
    assign result_o = is_jal ? link[DATA_W-1:0] : '0;

    always_comb begin
        resolved_o.valid    = data_i.valid;
        resolved_o.pc       = pc_i;
        resolved_o.target   = target;
        resolved_o.is_taken = taken;
        // wrong direction, or right direction to the wrong place
        resolved_o.is_mispredict = data_i.valid
            & ((predict_i.taken != taken) | (taken & (predict_i.target != target)));
    end

endmodule

//--- ex_csr_buffer.sv
// single-entry csr address buffer, released by commit or flush
`timescale 1ns/10ps

module ex_csr_buffer #(
    parameter int unsigned DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  logic                          csr_commit_i,
    input  ex_pkg::issue_slot_t           data_i,
    output logic [DATA_W-1:0]             result_o,
    output logic                          full_o,
    output logic [ex_pkg::CSR_ADDR_W-1:0] csr_addr_o
);
    import ex_pkg::*;

    logic                  full_q;
    logic [CSR_ADDR_W-1:0] addr_q;

    // value goes out at issue, write happens at commit
    assign result_o   = data_i.operand_a[DATA_W-1:0];
    assign full_o     = full_q;
    assign csr_addr_o = addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q <= 1'b0;
            addr_q <= '0;
        end else if (flush_i || csr_commit_i) begin
            // free again next cycle
            full_q <= 1'b0;
            addr_q <= '0;
        end else if (data_i.valid && !full_q) begin
            full_q <= 1'b1;
            addr_q <= data_i.imm[CSR_ADDR_W-1:0];
        end
    end

endmodule

//--- ex_mult_fsm.sv
// multiplier control fsm with idle, busy and done states
`timescale 1ns/10ps

module ex_mult_fsm (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    input  logic start_i,
    input  logic count_done_i,
    output logic load_o,
    output logic step_o,
    output logic done_o,
    output logic idle_o
);

    typedef enum logic [1:0] {IDLE, BUSY, DONE} state_e;

    state_e state_q, state_d;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (start_i) state_d = BUSY;
            // last step happens in the cycle the counter reads zero
            BUSY:    if (count_done_i) state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
        // flush drops the multiply without a result
        if (flush_i) state_d = IDLE;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) state_q <= IDLE;
        else         state_q <= state_d;
    end

    // busy for DATA_W cycles, done is cycle DATA_W + 1 after accept
    assign idle_o = (state_q == IDLE);
    assign load_o = idle_o & start_i & ~flush_i;
    assign step_o = (state_q == BUSY);
    assign done_o = (state_q == DONE) & ~flush_i;

endmodule

//--- ex_mult_counter.sv
// down-counter for multiplier bit steps with terminal-count flag
`timescale 1ns/10ps

module ex_mult_counter #(
    parameter int unsigned DATA_W = 32
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic load_i,
    input  logic dec_i,
    output logic done_o
);

    localparam int unsigned CNT_W = $clog2(DATA_W);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)                        cnt_q <= '0;
        else if (load_i)                    cnt_q <= CNT_W'(DATA_W - 1);
        // hold at zero until reloaded
        else if (dec_i && cnt_q != '0)      cnt_q <= cnt_q - 1'b1;
    end

    assign done_o = (cnt_q == '0);

endmodule

//--- ex_mult_datapath.sv
// shift-add multiplier registers and held transaction id
`timescale 1ns/10ps

module ex_mult_datapath #(
    parameter int unsigned DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          load_i,
    input  logic                          step_i,
    input  ex_pkg::issue_slot_t           data_i,
    output logic [DATA_W-1:0]             result_o,
    output logic [ex_pkg::TRANS_ID_W-1:0] trans_id_o
);
    import ex_pkg::*;

    logic [DATA_W-1:0]     mcand_q;
    logic [DATA_W-1:0]     mplier_q;
    logic [DATA_W-1:0]     acc_q;
    logic [TRANS_ID_W-1:0] trans_id_q;

    // operand shifters
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            mcand_q  <= data_i.operand_a[DATA_W-1:0];
            mplier_q <= data_i.operand_b[DATA_W-1:0];
        end else if (step_i) begin
            // multiplicand walks left, multiplier bits walk right
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    // accumulator keeps only the low product
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            acc_q      <= '0;
            trans_id_q <= '0;
        end else if (load_i) begin
            acc_q      <= '0;
            trans_id_q <= data_i.trans_id;
        end else if (step_i && mplier_q[0]) begin
            acc_q      <= acc_q + mcand_q;
        end
    end

    assign result_o   = acc_q;
    assign trans_id_o = trans_id_q;

endmodule

//--- ex_dispatch.sv
// slot routing, operand silencing, mispredict squash and write-back muxing
`timescale 1ns/10ps

module ex_dispatch #(
    parameter int unsigned DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input  ex_pkg::issue_slot_t               slot0_i,
    input  ex_pkg::issue_slot_t               slot1_i,
    input  logic [DATA_W-1:0]                 alu0_result_i,
    input  logic [DATA_W-1:0]                 alu1_result_i,
    input  logic [DATA_W-1:0]                 branch_result_i,
    input  ex_pkg::bp_resolve_t               resolve_i,
    input  logic [DATA_W-1:0]                 csr_result_i,
    input  logic                              csr_full_i,
    input  logic                              mult_idle_i,
    input  logic                              mult_done_i,
    input  logic [DATA_W-1:0]                 mult_result_i,
    input  logic [ex_pkg::TRANS_ID_W-1:0]     mult_trans_id_i,
    output ex_pkg::issue_slot_t               alu0_data_o,
    output ex_pkg::issue_slot_t               alu1_data_o,
    output ex_pkg::issue_slot_t               branch_data_o,
    output ex_pkg::issue_slot_t               csr_data_o,
    output logic                              mult_start_o,
    output ex_pkg::issue_slot_t               mult_data_o,
    output logic [1:0]                        ready_o,
    output ex_pkg::wb_port_t [1:0]            wb_o
);
    import ex_pkg::*;

    logic accept0, accept1;
    logic squash;
    logic go_mul;
    logic [DATA_W-1:0] res0;

    // ------------------------------------------------------------------
    // issue handshake
    // ------------------------------------------------------------------
    // csr buffer full blocks slot 0, a running multiply blocks slot 1
    assign ready_o[0] = ~csr_full_i;
    assign ready_o[1] = mult_idle_i;
    assign accept0    = slot0_i.valid & ready_o[0];
    assign accept1    = slot1_i.valid & ready_o[1];

    // younger slot dies behind a mispredicted branch in slot 0
    assign squash = resolve_i.valid & resolve_i.is_mispredict;

    // ------------------------------------------------------------------
    // operand silencing, idle units see all zeros
    // ------------------------------------------------------------------
    // alu 0 also does the compare for branches
    assign alu0_data_o   = (accept0 && (slot0_i.unit == ALU || slot0_i.unit == BRANCH))
                         ? slot0_i : '0;
    assign branch_data_o = (accept0 && slot0_i.unit == BRANCH) ? slot0_i : '0;
    assign csr_data_o    = (accept0 && slot0_i.unit == CSR) ? slot0_i : '0;
    assign alu1_data_o   = (accept1 && slot1_i.unit == ALU && !squash) ? slot1_i : '0;

    // squashed mul never starts
    assign go_mul       = accept1 && slot1_i.unit == MULT && !squash;
    assign mult_data_o  = go_mul ? slot1_i : '0;
    assign mult_start_o = go_mul;

    // ------------------------------------------------------------------
    // write-back port 0: alu, branch or csr
    // ------------------------------------------------------------------
    always_comb begin
        case (slot0_i.unit)
            BRANCH:  res0 = branch_result_i;
            CSR:     res0 = csr_result_i;
            default: res0 = alu0_result_i;
        endcase
        wb_o[0].valid    = accept0 && (slot0_i.unit == ALU || slot0_i.unit == BRANCH
                                       || slot0_i.unit == CSR);
        wb_o[0].flush    = 1'b0;
        wb_o[0].trans_id = slot0_i.trans_id;
        wb_o[0].result   = DATA_W_DEFAULT'(res0);
    end

    // ------------------------------------------------------------------
    // write-back port 1: multiplier completion, else slot 1 alu
    // ------------------------------------------------------------------
    // no collision, slot 1 is not ready while the multiplier is in done
    always_comb begin
        if (mult_done_i) begin
            wb_o[1].valid    = 1'b1;
            wb_o[1].flush    = 1'b0;
            wb_o[1].trans_id = mult_trans_id_i;
            wb_o[1].result   = DATA_W_DEFAULT'(mult_result_i);
        end else begin
            wb_o[1].valid    = accept1 && slot1_i.unit == ALU && !squash;
            // flush applies to a squashed alu op or mul alike
            wb_o[1].flush    = accept1 && squash;
            wb_o[1].trans_id = slot1_i.trans_id;
            wb_o[1].result   = DATA_W_DEFAULT'(alu1_result_i);
        end
    end

endmodule

//--- ex_stage_top.sv
// dual-issue execute stage top level, instances and wiring
`timescale 1ns/10ps

module ex_stage_top #(
    parameter int unsigned DATA_W = ex_pkg::DATA_W_DEFAULT
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  logic                          csr_commit_i,
    input  ex_pkg::issue_slot_t           slot0_i,
    input  ex_pkg::issue_slot_t           slot1_i,
    input  logic [31:0]                   pc_i,
    input  ex_pkg::branch_predict_t       predict_i,
    output logic [1:0]                    ready_o,
    output ex_pkg::wb_port_t [1:0]        wb_o,
    output ex_pkg::bp_resolve_t           resolved_o,
    output logic [ex_pkg::CSR_ADDR_W-1:0] csr_addr_o
);
    import ex_pkg::*;

    // silenced unit inputs
    issue_slot_t alu0_data, alu1_data, branch_data, csr_data, mult_data;
    // unit results
    logic [DATA_W-1:0] alu0_result, alu1_result, branch_result, csr_result, mult_result;
    logic              alu_cmp;
    logic              csr_full;
    // multiplier control
    logic mult_start, mult_load, mult_step, mult_done, mult_idle, cnt_done;
    logic [TRANS_ID_W-1:0] mult_trans_id;

    ex_dispatch #(.DATA_W(DATA_W)) u_dispatch (
        .slot0_i, .slot1_i,
        .alu0_result_i(alu0_result), .alu1_result_i(alu1_result),
        .branch_result_i(branch_result), .resolve_i(resolved_o),
        .csr_result_i(csr_result), .csr_full_i(csr_full),
        .mult_idle_i(mult_idle), .mult_done_i(mult_done),
        .mult_result_i(mult_result), .mult_trans_id_i(mult_trans_id),
        .alu0_data_o(alu0_data), .alu1_data_o(alu1_data),
        .branch_data_o(branch_data), .csr_data_o(csr_data),
        .mult_start_o(mult_start), .mult_data_o(mult_data),
        .ready_o, .wb_o
    );

    // ------------------------------------------------------------------
    // fixed-latency units
    // ------------------------------------------------------------------
    // alu 0 feeds the branch compare, alu 1 compare is unused
    ex_alu #(.DATA_W(DATA_W)) u_alu0 (
        .data_i(alu0_data), .result_o(alu0_result), .cmp_o(alu_cmp)
    );
    ex_alu #(.DATA_W(DATA_W)) u_alu1 (
        .data_i(alu1_data), .result_o(alu1_result), .cmp_o()
    );

    ex_branch_unit #(.DATA_W(DATA_W)) u_branch (
        .data_i(branch_data), .pc_i, .predict_i, .cmp_i(alu_cmp),
        .result_o(branch_result), .resolved_o
    );

    ex_csr_buffer #(.DATA_W(DATA_W)) u_csr (
        .clk_i, .rst_ni, .flush_i, .csr_commit_i, .data_i(csr_data),
        .result_o(csr_result), .full_o(csr_full), .csr_addr_o
    );

    // ------------------------------------------------------------------
    // iterative multiplier
    // ------------------------------------------------------------------
    ex_mult_fsm u_mult_fsm (
        .clk_i, .rst_ni, .flush_i, .start_i(mult_start), .count_done_i(cnt_done),
        .load_o(mult_load), .step_o(mult_step), .done_o(mult_done), .idle_o(mult_idle)
    );

    ex_mult_counter #(.DATA_W(DATA_W)) u_mult_cnt (
        .clk_i, .rst_ni, .load_i(mult_load), .dec_i(mult_step), .done_o(cnt_done)
    );

    ex_mult_datapath #(.DATA_W(DATA_W)) u_mult_dp (
        .clk_i, .rst_ni, .load_i(mult_load), .step_i(mult_step), .data_i(mult_data),
        .result_o(mult_result), .trans_id_o(mult_trans_id)
    );

endmodule

//--- ex_stage_asserts.sv
// concurrent assertions on write-back ports and slot 1 ready
`timescale 1ns/10ps

module ex_stage_asserts (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [1:0]             ready_i,
    input  ex_pkg::wb_port_t [1:0] wb_i,
    input  logic                   mult_busy_i
);

    // a port writes back or flushes, never both
    a_valid_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(wb_i[0].valid && wb_i[0].flush) && !(wb_i[1].valid && wb_i[1].flush))
        else $error("write-back port shows valid and flush together");

    // running multiply keeps slot 1 closed
    a_mult_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_busy_i |-> !ready_i[1])
        else $error("slot 1 ready while the multiplier is busy");

endmodule

//--- tb_clock_gen.sv
// testbench clock and power-on reset generator
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset held low, released just after an edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

//--- tb_ex_stage.sv
// testbench: lfsr stimulus, reference model, per-cycle compare, watchdog, summary
`timescale 1ns/10ps

module tb_ex_stage;
    import ex_pkg::*;

    localparam int DATA_W = DATA_W_DEFAULT;
    localparam int N_ALU  = 40;
    localparam int N_BR   = 40;
    localparam int N_MUL  = 4;
    localparam int N_CSR  = 4;
    // all tests at their longest, plus reset and slack
    localparam int MAX_CYC = 16 + 8 + N_ALU + N_BR + (N_MUL + 2) * (DATA_W + 8)
                           + N_CSR * 8 + 50;
    localparam fu_op_e BR_OPS [5] = '{BEQ, BNE, BLT, BGEU, JAL};

    // expected outputs of one cycle
    typedef struct packed {
        logic [1:0]            ready;
        wb_port_t [1:0]        wb;
        bp_resolve_t           res;
        logic [CSR_ADDR_W-1:0] csr_addr;
    } expect_t;

    logic                  clk, rst_n, flush, csr_commit;
    issue_slot_t           slot0, slot1;
    logic [31:0]           pc;
    branch_predict_t       predict;
    logic [1:0]            ready;
    wb_port_t [1:0]        wb;
    bp_resolve_t           resolved;
    logic [CSR_ADDR_W-1:0] csr_addr;

    expect_t     exp_q[$];
    string       test_name = "reset";
    int          checks = 0;
    int          errors = 0;
    logic [31:0] lfsr = 32'h1100_a1a9;
    // model of the blocking units
    int                    mul_left = 0;
    wb_port_t              mul_wb;
    logic                  csr_full_m = 1'b0;
    logic [CSR_ADDR_W-1:0] csr_addr_m = '0;
    // handshake seen at the coming edge
    logic [1:0]            taken;

    tb_clock_gen #(.PERIOD_NS(4), .RST_CYCLES(16)) u_clk (.clk_o(clk), .rst_no(rst_n));

    ex_stage_top #(.DATA_W(DATA_W)) DUT (
        .clk_i(clk), .rst_ni(rst_n), .flush_i(flush), .csr_commit_i(csr_commit),
        .slot0_i(slot0), .slot1_i(slot1), .pc_i(pc), .predict_i(predict),
        .ready_o(ready), .wb_o(wb), .resolved_o(resolved), .csr_addr_o(csr_addr)
    );

    bind ex_stage_top ex_stage_asserts u_asserts (
        .clk_i, .rst_ni, .ready_i(ready_o), .wb_i(wb_o), .mult_busy_i(mult_step)
    );

    // ------------------------------------------------------------------
    // random source and reference model
    // ------------------------------------------------------------------
    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic issue_slot_t make_slot(fu_unit_e unit, fu_op_e op);
        issue_slot_t s;
        s.valid     = 1'b1;
        s.unit      = unit;
        s.op        = op;
        s.operand_a = rand_bits(32);
        s.operand_b = rand_bits(32);
        s.imm       = rand_bits(32);
        s.trans_id  = TRANS_ID_W'(rand_bits(TRANS_ID_W));
        return s;
    endfunction

    function automatic fu_op_e alu_op();
        return fu_op_e'(rand_bits(4) % 9);
    endfunction

    function automatic logic [31:0] alu_ref(fu_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            // shift amount is the low five bits
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SLT:     return {31'd0, $signed(a) < $signed(b)};
            SLTU:    return {31'd0, a < b};
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_taken(fu_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGEU:    return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    // expected write-back and resolution for the slots presented this cycle
    function automatic expect_t reference(issue_slot_t s0, issue_slot_t s1, logic [31:0] pc_v,
                                          branch_predict_t p, logic [1:0] rdy);
        expect_t     e;
        logic        acc0, acc1, tk, squash;
        logic [31:0] tgt;
        e       = '0;
        acc0    = s0.valid & rdy[0];
        acc1    = s1.valid & rdy[1];
        e.ready = rdy;
        if (acc0 && s0.unit == BRANCH) begin
            tk                  = branch_taken(s0.op, s0.operand_a, s0.operand_b);
            tgt                 = tk ? pc_v + s0.imm : pc_v + 32'd4;
            e.res.valid         = 1'b1;
            e.res.pc            = pc_v;
            e.res.target        = tgt;
            e.res.is_taken      = tk;
            e.res.is_mispredict = (p.taken != tk) || (tk && p.target != tgt);
        end
        squash = e.res.valid & e.res.is_mispredict;
        e.wb[0].valid    = acc0 && (s0.unit == ALU || s0.unit == BRANCH || s0.unit == CSR);
        e.wb[0].trans_id = s0.trans_id;
        case (s0.unit)
            BRANCH:  e.wb[0].result = (s0.op == JAL) ? pc_v + 32'd4 : '0;
            CSR:     e.wb[0].result = s0.operand_a;
            default: e.wb[0].result = alu_ref(s0.op, s0.operand_a, s0.operand_b);
        endcase
        // younger slot dies behind a mispredict
        e.wb[1].valid    = acc1 && s1.unit == ALU && !squash;
        e.wb[1].flush    = acc1 && squash;
        e.wb[1].trans_id = s1.trans_id;
        e.wb[1].result   = alu_ref(s1.op, s1.operand_a, s1.operand_b);
        return e;
    endfunction

    // ------------------------------------------------------------------
    // checking
    // ------------------------------------------------------------------
    task automatic check(string what, logic [127:0] exp_v, logic [127:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
        end
    endtask

    // outputs have settled by the falling edge
    always @(negedge clk) begin
        expect_t e;
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check("ready", 128'(e.ready), 128'(ready));
            for (int i = 0; i < 2; i++) begin
                check($sformatf("wb%0d valid/flush", i), 128'({e.wb[i].valid, e.wb[i].flush}),
                      128'({wb[i].valid, wb[i].flush}));
                if (e.wb[i].valid || e.wb[i].flush)
                    check($sformatf("wb%0d trans_id", i), 128'(e.wb[i].trans_id),
                          128'(wb[i].trans_id));
                if (e.wb[i].valid)
                    check($sformatf("wb%0d result", i), 128'(e.wb[i].result),
                          128'(wb[i].result));
            end
            check("resolved valid", 128'(e.res.valid), 128'(resolved.valid));
            if (e.res.valid)
                check("resolution", 128'(e.res), 128'(resolved));
            check("csr_addr", 128'(e.csr_addr), 128'(csr_addr));
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    // queue this cycle's expectation, step the model, move to the next drive point
    task automatic next_cycle();
        expect_t    e;
        logic [1:0] rdy;
        rdy        = {mul_left == 0, !csr_full_m};
        e          = reference(slot0, slot1, pc, predict, rdy);
        e.csr_addr = csr_addr_m;
        // multiply completes in its last blocked cycle
        if (mul_left == 1 && !flush)
            e.wb[1] = mul_wb;
        exp_q.push_back(e);
        taken = {slot1.valid & ready[1], slot0.valid & ready[0]};
        if (flush || csr_commit) begin
            csr_full_m = 1'b0;
            csr_addr_m = '0;
        end else if (e.wb[0].valid && slot0.unit == CSR) begin
            csr_full_m = 1'b1;
            csr_addr_m = slot0.imm[CSR_ADDR_W-1:0];
        end
        if (flush) begin
            mul_left = 0;
        end else if (mul_left != 0) begin
            mul_left--;
        end else if (rdy[1] && slot1.valid && slot1.unit == MULT && !e.wb[1].flush) begin
            mul_left        = DATA_W + 1;
            mul_wb.valid    = 1'b1;
            mul_wb.flush    = 1'b0;
            mul_wb.trans_id = slot1.trans_id;
            mul_wb.result   = slot1.operand_a * slot1.operand_b;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        slot0      = '0;
        slot1      = '0;
        pc         = '0;
        predict    = '0;
        flush      = 1'b0;
        csr_commit = 1'b0;
    endtask

    // hold one slot on the inputs until the DUT takes it
    task automatic issue_held(int idx);
        int n;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (!taken[idx] && n < 2 * DATA_W);
        if (!taken[idx]) begin
            errors++;
            $display("%s: slot %0d was never accepted by the DUT", test_name, idx);
        end
        if (idx == 0)
            slot0 = '0;
        else
            slot1 = '0;
    endtask

    task automatic test_alu();
        test_name = "alu";
        for (int i = 0; i < N_ALU; i++) begin
            slot0 = make_slot(ALU, alu_op());
            slot1 = make_slot(ALU, alu_op());
            next_cycle();
        end
        idle_inputs();
    endtask

    task automatic test_branch();
        test_name = "branch";
        for (int i = 0; i < N_BR; i++) begin
            pc    = rand_bits(32) & 32'hffff_fffc;
            slot0 = make_slot(BRANCH, BR_OPS[rand_bits(3) % 5]);
            // equal operands now and then for beq and bgeu
            if (rand_bits(1) != 0)
                slot0.operand_b = slot0.operand_a;
            predict.taken  = 1'(rand_bits(1));
            predict.target = (rand_bits(1) != 0) ? pc + slot0.imm : rand_bits(32);
            slot1          = make_slot(ALU, alu_op());
            next_cycle();
        end
        // jal predicted not taken, the mul behind it must never start
        slot0         = make_slot(BRANCH, JAL);
        predict.taken = 1'b0;
        slot1         = make_slot(MULT, MUL);
        next_cycle();
        idle_inputs();
        next_cycle();
    endtask

    task automatic test_mul();
        test_name = "mul";
        for (int i = 0; i < N_MUL; i++) begin
            slot1 = make_slot(MULT, MUL);
            issue_held(1);
            // alu op waits behind the running multiply
            slot1 = make_slot(ALU, alu_op());
            issue_held(1);
        end
    endtask

    task automatic test_csr();
        test_name = "csr";
        for (int i = 0; i < N_CSR; i++) begin
            slot0 = make_slot(CSR, CSRRW);
            issue_held(0);
            slot0 = make_slot(CSR, CSRRW);
            repeat (3) next_cycle();
            csr_commit = 1'b1;
            next_cycle();
            csr_commit = 1'b0;
            issue_held(0);
            csr_commit = 1'b1;
            next_cycle();
            csr_commit = 1'b0;
        end
    endtask

    task automatic test_flush();
        test_name = "flush";
        slot0 = make_slot(CSR, CSRRW);
        slot1 = make_slot(MULT, MUL);
        next_cycle();
        idle_inputs();
        repeat (10) next_cycle();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        // long enough for a stray multiplier result to show
        repeat (DATA_W + 4) next_cycle();
    endtask

    initial begin
        idle_inputs();
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        repeat (4) next_cycle();
        test_alu();
        test_branch();
        test_mul();
        test_csr();
        test_flush();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // watchdog
    initial begin
        repeat (MAX_CYC) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", MAX_CYC);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- src.f
ex_pkg.sv
ex_alu.sv
ex_branch_unit.sv
ex_csr_buffer.sv
ex_mult_fsm.sv
ex_mult_counter.sv
ex_mult_datapath.sv
ex_dispatch.sv
ex_stage_top.sv
ex_stage_asserts.sv
tb_clock_gen.sv
tb_ex_stage.sv

//--- Makefile
# verilator build and run of the execute stage testbench

TOP := tb_ex_stage

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
